// ==== hw/mult16_cfg.svh ====
`ifndef MULT16_CFG_SVH
`define MULT16_CFG_SVH

// Operand and result widths

`define MULT_OPERAND_W  16  // A and B
`define MULT_HALF_W     8   // A bits per reducer

// Eight rows of B shifted by their bit positions
`define MULT_HALF_SUM_W 24

`define MULT_PRODUCT_W  32

`endif

// ==== hw/mult16_pkg.sv ====
`include "mult16_cfg.svh"

package mult16_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [`MULT_OPERAND_W-1:0] operand_t;

    // One byte of A for one reducer
    typedef logic [`MULT_HALF_W-1:0] half_operand_t;

    typedef struct packed {
        operand_t a;  // Gates the rows
        operand_t b;  // Row value
    } operand_pair_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Sum of eight weighted rows without the byte weight
    typedef logic [`MULT_HALF_SUM_W-1:0] half_sum_t;

    typedef logic [`MULT_PRODUCT_W-1:0] product_t;

endpackage

// ==== hw/gp_adder.sv ====
`timescale 1ns/1ps

module gp_adder #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0] in1,
    input  logic [WIDTH-1:0] in2,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [WIDTH-1:0] gen;
    logic [WIDTH-1:0] prop;
    logic [WIDTH:0]   carry;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-bit generate and propagate
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign gen  = in1 & in2;
    assign prop = in1 ^ in2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Carry chain, bit 0 first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign carry[0] = 1'b0;  // No carry-in

    for (genvar i = 0; i < WIDTH; i++) begin : g_carry
        // c[i+1] = g[i] + p[i]c[i]
        assign carry[i+1] = gen[i] | (prop[i] & carry[i]);
    end

    assign sum  = prop ^ carry[WIDTH-1:0];
    assign cout = carry[WIDTH];

endmodule

// ==== hw/pp_half_reducer.sv ====
`timescale 1ns/1ps
`include "mult16_cfg.svh"

module pp_half_reducer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mult16_pkg::half_operand_t a_half,
    input  mult16_pkg::operand_t      b,
    output mult16_pkg::half_sum_t     half_sum
);

    import mult16_pkg::*;

    // Adder widths per tree level
    localparam int L1_W = `MULT_OPERAND_W + 1;
    localparam int L2_W = L1_W + 2;
    localparam int L3_W = L2_W + 4;

    localparam int ROWS = `MULT_HALF_W;

    operand_t rows [ROWS];

    logic [L1_W-1:0] l1_add  [ROWS/2];
    logic            l1_cout [ROWS/2];
    logic [L1_W:0]   l1_sum  [ROWS/2];  // Carry on top

    logic [L2_W-1:0] l2_add  [ROWS/4];
    logic            l2_cout [ROWS/4];
    logic [L2_W+1:0] l2_sum  [ROWS/4];

    logic [L3_W-1:0] l3_add;
    logic            l3_cout;
    logic [L3_W+2:0] l3_sum;

    half_sum_t sum_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Partial-product rows
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < ROWS; i++) begin : g_row
        assign rows[i] = a_half[i] ? b : '0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Level 1 adds row pairs with the odd row one place up
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < ROWS/2; i++) begin : g_lvl1
        gp_adder #(
            .WIDTH (L1_W)
        ) u_add (
            .in1  ({1'b0, rows[2*i]}),
            .in2  ({rows[2*i+1], 1'b0}),
            .sum  (l1_add[i]),
            .cout (l1_cout[i])
        );

        assign l1_sum[i] = {l1_cout[i], l1_add[i]};
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Level 2 adds sums two places apart
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bit 0 of the lower sum has no partner and goes around the adder
    for (genvar j = 0; j < ROWS/4; j++) begin : g_lvl2
        gp_adder #(
            .WIDTH (L2_W)
        ) u_add (
            .in1  ({2'b00, l1_sum[2*j][L1_W:1]}),
            .in2  ({l1_sum[2*j+1], 1'b0}),
            .sum  (l2_add[j]),
            .cout (l2_cout[j])
        );

        assign l2_sum[j] = {l2_cout[j], l2_add[j], l1_sum[2*j][0]};
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Level 3 adds sums four places apart
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    gp_adder #(
        .WIDTH (L3_W)
    ) u_lvl3_add (
        .in1  ({4'b0000, l2_sum[0][L2_W+1:2]}),  // Low two bits bypass
        .in2  ({l2_sum[1], 2'b00}),
        .sum  (l3_add),
        .cout (l3_cout)
    );

    assign l3_sum = {l3_cout, l3_add, l2_sum[0][1:0]};

    // Upper bits beyond 24 are always zero for 8 x 16 bits
    assign sum_next = l3_sum[`MULT_HALF_SUM_W-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_sum <= '0;
        end else begin
            half_sum <= sum_next;  // Every edge
        end
    end

endmodule

// ==== hw/product_combiner.sv ====
`timescale 1ns/1ps
`include "mult16_cfg.svh"

module product_combiner (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  mult16_pkg::half_sum_t lo_sum,
    input  mult16_pkg::half_sum_t hi_sum,
    output mult16_pkg::product_t  product,
    output logic                  out_valid
);

    import mult16_pkg::*;

    logic valid_d1;  // Lines up with the reducer registers

    half_sum_t                 lo_upper;
    half_sum_t                 upper_add;
    logic                      upper_cout;
    logic [`MULT_HALF_SUM_W:0] upper_sum;

    product_t product_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Weight-eight addition
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Only the part of lo_sum above the byte boundary meets hi_sum
    assign lo_upper = {{`MULT_HALF_W{1'b0}}, lo_sum[`MULT_HALF_SUM_W-1:`MULT_HALF_W]};

    gp_adder #(
        .WIDTH (`MULT_HALF_SUM_W)
    ) u_upper_add (
        .in1  (lo_upper),
        .in2  (hi_sum),
        .sum  (upper_add),
        .cout (upper_cout)
    );

    assign upper_sum = {upper_cout, upper_add};

    // Carry out of the top never sets for 16 x 16 bits
    assign product_next = {upper_sum[`MULT_HALF_SUM_W-1:0], lo_sum[`MULT_HALF_W-1:0]};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Valid tracking and product register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d1  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_d1  <= in_valid;
            out_valid <= valid_d1;  // One-cycle pulse per strobe
        end
    end

    // Holds between results
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product <= '0;
        end else if (valid_d1) begin
            product <= product_next;
        end
    end

endmodule

// ==== hw/mult16_top.sv ====
`timescale 1ns/1ps
`include "mult16_cfg.svh"

module mult16_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  mult16_pkg::operand_pair_t operands,
    output mult16_pkg::product_t      product,
    output logic                      out_valid
);

    import mult16_pkg::*;

    half_operand_t a_lo;
    half_operand_t a_hi;

    half_sum_t lo_sum;
    half_sum_t hi_sum;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte split of A
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign a_lo = operands.a[`MULT_HALF_W-1:0];
    assign a_hi = operands.a[`MULT_OPERAND_W-1:`MULT_HALF_W];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reducers side by side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    pp_half_reducer u_lo_reducer (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_half   (a_lo),
        .b        (operands.b),
        .half_sum (lo_sum)
    );

    // Same rows with the weight applied in the combiner
    pp_half_reducer u_hi_reducer (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_half   (a_hi),
        .b        (operands.b),
        .half_sum (hi_sum)
    );

    product_combiner u_combiner (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .lo_sum    (lo_sum),
        .hi_sum    (hi_sum),
        .product   (product),
        .out_valid (out_valid)
    );

endmodule

// ==== verif/mult16_assertions.sv ====
`timescale 1ns/1ps

module mult16_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      in_valid,
    input mult16_pkg::operand_pair_t operands,
    input mult16_pkg::product_t      product,
    input logic                      out_valid
);

    import mult16_pkg::*;

    int fail_count = 0;

    // Reference pipeline as deep as the DUT
    logic     valid_d1;
    logic     valid_d2;
    product_t expect_d1;
    product_t expect_d2;
    product_t product_prev;  // Product at the previous edge

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Expected values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d1     <= 1'b0;
            valid_d2     <= 1'b0;
            expect_d1    <= '0;
            expect_d2    <= '0;
            product_prev <= '0;
        end else begin
            valid_d1     <= in_valid;
            valid_d2     <= valid_d1;
            expect_d1    <= product_t'(operands.a) * product_t'(operands.b);
            expect_d2    <= expect_d1;
            product_prev <= product;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Arithmetic product of the pair strobed two edges back
    a_product_value: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> product == expect_d2)
    else begin
        fail_count++;
        $error("[ERROR] %0t product expected %h actual %h",
               $time, $sampled(expect_d2), $sampled(product));
    end

    // One pulse per strobe two edges later and none otherwise
    a_pulse_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == valid_d2)
    else begin
        fail_count++;
        $error("[ERROR] %0t out_valid expected %b actual %b",
               $time, $sampled(valid_d2), $sampled(out_valid));
    end

    a_idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> product == product_prev)
    else begin
        fail_count++;
        $error("[ERROR] %0t product changed without out_valid, was %h now %h",
               $time, $sampled(product_prev), $sampled(product));
    end

    // In reset and at the first edge after release
    a_reset_state: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (!out_valid && product == '0))
    else begin
        fail_count++;
        $error("[ERROR] %0t reset out_valid expected 0 actual %b, product expected 0 actual %h",
               $time, $sampled(out_valid), $sampled(product));
    end

endmodule

// ==== verif/tb_mult16.sv ====
`timescale 1ns/1ps

module tb_mult16;

    import mult16_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_DIRECTED = 9;
    localparam int NUM_RANDOM   = 400;
    localparam int MAX_GAP      = 3;
    localparam int BURST_LEN    = 32;
    localparam int DRAIN_CYCLES = 6;

    // Worst case with the longest gap after every random pair
    localparam int TEST_CYCLES = RESET_CYCLES + NUM_DIRECTED + 2
                               + NUM_RANDOM * (1 + MAX_GAP)
                               + BURST_LEN + DRAIN_CYCLES + 1;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 20) * CLK_PERIOD;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    operand_pair_t operands;
    product_t      product;
    logic          out_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // DUT and checkers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mult16_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .operands  (operands),
        .product   (product),
        .out_valid (out_valid)
    );

    bind mult16_top mult16_assertions u_assertions (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .operands  (operands),
        .product   (product),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic operand_t random_operand();
        return operand_t'($urandom);
    endfunction

    function automatic operand_pair_t random_pair();
        operand_pair_t pair;
        pair.a = random_operand();
        pair.b = random_operand();
        return pair;
    endfunction

    task automatic send_pair(input operand_t a, input operand_t b);
        @(posedge clk);
        in_valid   <= 1'b1;
        operands.a <= a;
        operands.b <= b;
    endtask

    // Operand bus keeps moving while idle
    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            in_valid <= 1'b0;
            operands <= random_pair();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(32'h109b));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        operands     = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Corner operands
        send_pair(16'h0000, random_operand());
        send_pair(random_operand(), 16'h0000);
        send_pair(16'h0001, random_operand());
        send_pair(random_operand(), 16'h0001);
        send_pair(16'hffff, 16'hffff);
        send_pair(16'h00a5, random_operand());  // Low reducer only
        send_pair(16'h5a00, random_operand());  // High reducer only
        send_pair(16'h00ff, 16'hffff);
        send_pair(16'hff00, 16'hffff);
        idle(2);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_pair(random_operand(), random_operand());
            idle($urandom % (MAX_GAP + 1));
        end

        // Back-to-back burst
        for (int i = 0; i < BURST_LEN; i++) begin
            send_pair(random_operand(), random_operand());
        end

        idle(DRAIN_CYCLES);
        @(negedge clk);

        if (dut0.u_assertions.fail_count != 0) begin
            $display("TB FAILED");
            $fatal(1, "%0d assertion failures", dut0.u_assertions.fail_count);
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure monitor and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Stops at the first failed assertion
    initial begin
        wait (dut0.u_assertions.fail_count != 0);
        $display("TB FAILED");
        $fatal(1, "assertion failed at %0t", $time);
    end

    initial begin
        #(WATCHDOG_NS);
        $display("TB FAILED");
        $fatal(1, "watchdog expired after %0d ns before the sequence ended", WATCHDOG_NS);
    end

endmodule

// ==== mult16.f ====
+incdir+hw
hw/mult16_pkg.sv
hw/gp_adder.sv
hw/pp_half_reducer.sv
hw/product_combiner.sv
hw/mult16_top.sv
verif/mult16_assertions.sv
verif/tb_mult16.sv
